// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - include_dirs:
      - .
    files:
      - mipsPkg.sv
      - aluDecoder.sv
      - alu.sv
      - regFile.sv
      - multicycleDatapath.sv
      - controlUnit.sv
      - mipsCore.sv
      - target: test
        files:
          - mipsCore_asserts.sv
          - tb_mipsCore.sv

// ==== alu.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"
`default_nettype none

module alu (
	input wire [`MIPS_XLEN-1:0] a,
	input wire [`MIPS_XLEN-1:0] b,
	input wire mipsPkg::aluCtrl aluControl,
	output logic [`MIPS_XLEN-1:0] result,
	output logic zero
);

	// Signed compare for slt
	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluControl)
			mipsPkg::aluAnd: begin
				result = a & b;
			end
			mipsPkg::aluOr: begin
				result = a | b;
			end
			mipsPkg::aluAdd: begin
				result = a + b;
			end
			mipsPkg::aluSub: begin
				result = a - b;
			end
			// One in bit 0, zeros above
			mipsPkg::aluSlt: begin
				result = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
			end
			default: begin
				result = a + b;
			end
		endcase
	end

	// Equality flag for beq
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== aluDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluDecoder (
	input wire mipsPkg::aluOpClass aluOp,
	input wire [5:0] funct,
	output mipsPkg::aluCtrl aluControl
);

	// Second-level decode of the ALU function
	always_comb begin
		// Address and addi work is an add
		aluControl = mipsPkg::aluAdd;
		case (aluOp)
			mipsPkg::addOp: begin
				aluControl = mipsPkg::aluAdd;
			end
			// beq compares by subtracting
			mipsPkg::subOp: begin
				aluControl = mipsPkg::aluSub;
			end
			// R-type, funct picks the operation
			mipsPkg::functOp: begin
				case (funct)
					mipsPkg::functAdd: aluControl = mipsPkg::aluAdd;
					mipsPkg::functSub: aluControl = mipsPkg::aluSub;
					mipsPkg::functAnd: aluControl = mipsPkg::aluAnd;
					mipsPkg::functOr:  aluControl = mipsPkg::aluOr;
					mipsPkg::functSlt: aluControl = mipsPkg::aluSlt;
					// Unknown funct falls back to add
					default:           aluControl = mipsPkg::aluAdd;
				endcase
			end
			default: begin
				aluControl = mipsPkg::aluAdd;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
	input wire cclk,
	input wire rstb,
	input wire [5:0] opcode,
	input wire [5:0] funct,
	// Mux selects
	output logic iOrD,
	output logic memToReg,
	output logic regDst,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [1:0] pcSrc,
	// Register and memory enables
	output logic irWrite,
	output logic pcWrite,
	output logic branch,
	output logic regWrite,
	output logic memWrite,
	output mipsPkg::aluCtrl aluControl
);

	mipsPkg::ctrlState state;
	mipsPkg::ctrlState nextState;
	mipsPkg::aluOpClass aluOp;

	aluDecoder aluDecoder_i (
		.aluOp      (aluOp),
		.funct      (funct),
		.aluControl (aluControl)
	);

	// State register
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= mipsPkg::fetch;
		end else begin
			state <= nextState;
		end
	end

	// Transition graph
	always_comb begin
		// Last state of every path goes back to fetch
		nextState = mipsPkg::fetch;
		case (state)
			mipsPkg::fetch: nextState = mipsPkg::decode;
			mipsPkg::decode: begin
				case (opcode)
					mipsPkg::lw, mipsPkg::sw: nextState = mipsPkg::memAdr;
					mipsPkg::rType:           nextState = mipsPkg::execute;
					mipsPkg::beq:             nextState = mipsPkg::branch;
					mipsPkg::addi:            nextState = mipsPkg::itypeExecute;
					mipsPkg::j:               nextState = mipsPkg::jump;
					// Unknown opcode, skip the word
					default:                  nextState = mipsPkg::fetch;
				endcase
			end
			// Load or store split
			mipsPkg::memAdr: begin
				if (opcode == mipsPkg::lw) begin
					nextState = mipsPkg::memRead;
				end else if (opcode == mipsPkg::sw) begin
					nextState = mipsPkg::memWrite;
				end
			end
			mipsPkg::memRead:      nextState = mipsPkg::memWriteback;
			mipsPkg::execute:      nextState = mipsPkg::aluWriteback;
			mipsPkg::itypeExecute: nextState = mipsPkg::itypeWriteback;
			default:               nextState = mipsPkg::fetch;
		endcase
	end

	// Moore outputs, everything off unless the state says otherwise
	always_comb begin
		iOrD = 1'b0;
		memToReg = 1'b0;
		regDst = 1'b0;
		aluSrcA = 1'b0;
		aluSrcB = 2'b00;
		pcSrc = 2'b00;
		irWrite = 1'b0;
		pcWrite = 1'b0;
		branch = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		aluOp = mipsPkg::addOp;
		case (state)
			// Load IR from mem[PC] and step PC by 4
			mipsPkg::fetch: begin
				aluSrcB = 2'b01;
				irWrite = 1'b1;
				pcWrite = 1'b1;
			end
			// Precompute branch target into ALUOut
			mipsPkg::decode: begin
				aluSrcB = 2'b11;
			end
			// rs + imm, also used by addi
			mipsPkg::memAdr, mipsPkg::itypeExecute: begin
				aluSrcA = 1'b1;
				aluSrcB = 2'b10;
			end
			mipsPkg::memRead: begin
				iOrD = 1'b1;
			end
			// MDR into rt
			mipsPkg::memWriteback: begin
				memToReg = 1'b1;
				regWrite = 1'b1;
			end
			mipsPkg::memWrite: begin
				iOrD = 1'b1;
				memWrite = 1'b1;
			end
			mipsPkg::execute: begin
				aluSrcA = 1'b1;
				aluOp = mipsPkg::functOp;
			end
			// ALUOut into rd
			mipsPkg::aluWriteback: begin
				regDst = 1'b1;
				regWrite = 1'b1;
			end
			// rs - rt, PC takes ALUOut on zero
			mipsPkg::branch: begin
				aluSrcA = 1'b1;
				aluOp = mipsPkg::subOp;
				pcSrc = 2'b01;
				branch = 1'b1;
			end
			// ALUOut into rt
			mipsPkg::itypeWriteback: begin
				regWrite = 1'b1;
			end
			mipsPkg::jump: begin
				pcSrc = 2'b10;
				pcWrite = 1'b1;
			end
			default: begin
				aluOp = mipsPkg::addOp;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
mipsPkg.sv
aluDecoder.sv
alu.sv
regFile.sv
multicycleDatapath.sv
controlUnit.sv
mipsCore.sv
mipsCore_asserts.sv
tb_mipsCore.sv

// ==== mipsCore.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"
`default_nettype none

module mipsCore (
	input wire cclk,
	input wire rstb,
	// Shared instruction and data port
	output logic [`MIPS_XLEN-1:0] memAddr,
	output logic [`MIPS_XLEN-1:0] memWData,
	output logic memWrite,
	input wire [`MIPS_XLEN-1:0] memRData
);

	// Controller to datapath
	wire iOrD;
	wire memToReg;
	wire regDst;
	wire aluSrcA;
	wire [1:0] aluSrcB;
	wire [1:0] pcSrc;
	wire irWrite;
	wire pcWrite;
	wire branch;
	wire regWrite;
	mipsPkg::aluCtrl aluControl;

	// Datapath back to controller
	wire [5:0] opcode;
	wire [5:0] funct;

	controlUnit controlUnit_i (
		.cclk       (cclk),
		.rstb       (rstb),
		.opcode     (opcode),
		.funct      (funct),
		.iOrD       (iOrD),
		.memToReg   (memToReg),
		.regDst     (regDst),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.pcSrc      (pcSrc),
		.irWrite    (irWrite),
		.pcWrite    (pcWrite),
		.branch     (branch),
		.regWrite   (regWrite),
		.memWrite   (memWrite),
		.aluControl (aluControl)
	);

	multicycleDatapath multicycleDatapath_i (
		.cclk       (cclk),
		.rstb       (rstb),
		.iOrD       (iOrD),
		.memToReg   (memToReg),
		.regDst     (regDst),
		.aluSrcA    (aluSrcA),
		.aluSrcB    (aluSrcB),
		.pcSrc      (pcSrc),
		.irWrite    (irWrite),
		.pcWrite    (pcWrite),
		.branch     (branch),
		.regWrite   (regWrite),
		.aluControl (aluControl),
		.memRData   (memRData),
		.memAddr    (memAddr),
		.memWData   (memWData),
		.opcode     (opcode),
		.funct      (funct)
	);

endmodule

`default_nettype wire

// ==== mipsCore_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module mipsCore_asserts (
	input wire cclk,
	input wire rstb,
	input wire mipsPkg::ctrlState state,
	input wire irWrite,
	input wire regWrite,
	input wire memWrite
);

	// Number of assertion failures
	int assertFails = 0;

	// Store strobe comes only from the memWrite state
	memWriteInState: assert property (@(posedge cclk) disable iff (!rstb)
		memWrite |-> (state == mipsPkg::memWrite))
	else begin
		assertFails++;
		$error("memWrite high outside the memWrite state");
	end

	// IR loads only in fetch
	irWriteInFetch: assert property (@(posedge cclk) disable iff (!rstb)
		irWrite |-> (state == mipsPkg::fetch))
	else begin
		assertFails++;
		$error("irWrite high outside the fetch state");
	end

	// Register and memory writes never share a cycle
	noDoubleWrite: assert property (@(posedge cclk) disable iff (!rstb)
		!(regWrite && memWrite))
	else begin
		assertFails++;
		$error("regWrite and memWrite high in the same cycle");
	end

endmodule

bind controlUnit mipsCore_asserts mipsCore_asserts_i (
	.cclk     (cclk),
	.rstb     (rstb),
	.state    (state),
	.irWrite  (irWrite),
	.regWrite (regWrite),
	.memWrite (memWrite)
);

`default_nettype wire

// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	// Controller states
	typedef enum logic [3:0] {
		fetch          = 4'd0,
		decode         = 4'd1,
		memAdr         = 4'd2,
		memRead        = 4'd3,
		memWriteback   = 4'd4,
		memWrite       = 4'd5,
		execute        = 4'd6,
		aluWriteback   = 4'd7,
		branch         = 4'd8,
		itypeExecute   = 4'd9,
		itypeWriteback = 4'd10,
		jump           = 4'd11
	} ctrlState;

	// Primary opcode field in instr[31:26]
	typedef enum logic [5:0] {
		rType = 6'd0,
		j     = 6'd2,
		beq   = 6'd4,
		addi  = 6'd8,
		lw    = 6'd35,
		sw    = 6'd43
	} opcode;

	// R-type funct field in instr[5:0]
	typedef enum logic [5:0] {
		functAdd = 6'h20,
		functSub = 6'h22,
		functAnd = 6'h24,
		functOr  = 6'h25,
		functSlt = 6'h2a
	} functCode;

	// Operation class from the FSM to the ALU decoder
	typedef enum logic [1:0] {
		addOp   = 2'b00,
		subOp   = 2'b01,
		functOp = 2'b10
	} aluOpClass;

	// ALU function select in the classic MIPS encoding
	typedef enum logic [3:0] {
		aluAnd = 4'd0,
		aluOr  = 4'd1,
		aluAdd = 4'd2,
		aluSub = 4'd6,
		aluSlt = 4'd7
	} aluCtrl;

endpackage

`default_nettype wire

// ==== mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath and address width
`define MIPS_XLEN 32

// Architectural register count
// Register 0 reads as zero
`define MIPS_NREGS 32

// First fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== multicycleDatapath.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"
`default_nettype none

module multicycleDatapath (
	input wire cclk,
	input wire rstb,
	// Mux selects
	input wire iOrD,
	input wire memToReg,
	input wire regDst,
	input wire aluSrcA,
	input wire [1:0] aluSrcB,
	input wire [1:0] pcSrc,
	// Register enables
	input wire irWrite,
	input wire pcWrite,
	input wire branch,
	input wire regWrite,
	input wire mipsPkg::aluCtrl aluControl,
	// Shared memory port
	input wire [`MIPS_XLEN-1:0] memRData,
	output logic [`MIPS_XLEN-1:0] memAddr,
	output logic [`MIPS_XLEN-1:0] memWData,
	// Instruction fields back to the FSM
	output logic [5:0] opcode,
	output logic [5:0] funct
);

	// Architectural and internal registers
	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] instr;
	logic [`MIPS_XLEN-1:0] mdr;
	logic [`MIPS_XLEN-1:0] aReg;
	logic [`MIPS_XLEN-1:0] bReg;
	logic [`MIPS_XLEN-1:0] aluOut;

	logic [`MIPS_XLEN-1:0] rd1;
	logic [`MIPS_XLEN-1:0] rd2;
	logic [`MIPS_XLEN-1:0] srcA;
	logic [`MIPS_XLEN-1:0] srcB;
	logic [`MIPS_XLEN-1:0] aluResult;
	logic [`MIPS_XLEN-1:0] signImm;
	logic [`MIPS_XLEN-1:0] pcNext;
	logic [`MIPS_XLEN-1:0] writeData;
	logic [4:0] writeReg;
	logic zero;
	logic pcEn;

	// Program counter
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= `MIPS_RESET_PC;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// IR loads in fetch only
	// MDR, A, B and ALUOut load every cycle
	always_ff @(posedge cclk) begin
		if (irWrite) begin
			instr <= memRData;
		end
		mdr <= memRData;
		aReg <= rd1;
		bReg <= rd2;
		aluOut <= aluResult;
	end

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	// Instruction or data address
	assign memAddr = iOrD ? aluOut : pc;
	// sw data comes from rt
	assign memWData = bReg;

	// rd for R-type, rt for lw and addi
	assign writeReg = regDst ? instr[15:11] : instr[20:16];
	assign writeData = memToReg ? mdr : aluOut;

	regFile regFile_i (
		.cclk (cclk),
		.rstb (rstb),
		.ra1  (instr[25:21]),
		.ra2  (instr[20:16]),
		.wa   (writeReg),
		.we   (regWrite),
		.wd   (writeData),
		.rd1  (rd1),
		.rd2  (rd2)
	);

	// All kept immediates are sign-extended
	assign signImm = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};

	// Operand A is PC or rs
	assign srcA = aluSrcA ? aReg : pc;

	// Operand B is rt, 4, imm or imm*4 for branch offsets
	always_comb begin
		case (aluSrcB)
			2'b00:   srcB = bReg;
			2'b01:   srcB = `MIPS_XLEN'd4;
			2'b10:   srcB = signImm;
			default: srcB = {signImm[`MIPS_XLEN-3:0], 2'b00};
		endcase
	end

	alu alu_i (
		.a          (srcA),
		.b          (srcB),
		.aluControl (aluControl),
		.result     (aluResult),
		.zero       (zero)
	);

	// Next PC
	// PC+4 straight off the ALU, branch target held in ALUOut, or jump
	always_comb begin
		case (pcSrc)
			2'b00:   pcNext = aluResult;
			2'b01:   pcNext = aluOut;
			2'b10:   pcNext = {pc[`MIPS_XLEN-1:28], instr[25:0], 2'b00};
			default: pcNext = aluResult;
		endcase
	end

	// Taken beq needs rs == rt
	assign pcEn = pcWrite | (branch & zero);

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"
`default_nettype none

module regFile (
	input wire cclk,
	input wire rstb,
	input wire [$clog2(`MIPS_NREGS)-1:0] ra1,
	input wire [$clog2(`MIPS_NREGS)-1:0] ra2,
	input wire [$clog2(`MIPS_NREGS)-1:0] wa,
	input wire we,
	input wire [`MIPS_XLEN-1:0] wd,
	output logic [`MIPS_XLEN-1:0] rd1,
	output logic [`MIPS_XLEN-1:0] rd2
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	// Single write port, writes to r0 dropped
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// Combinational reads
	// r0 forced to zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== tb_mipsCore.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"
`default_nettype none

module tb_mipsCore;

	localparam int MemWords = 512;
	localparam int NumTests = 6;

	logic cclk;
	logic rstb;
	logic [`MIPS_XLEN-1:0] memAddr;
	logic [`MIPS_XLEN-1:0] memWData;
	logic memWrite;
	logic [`MIPS_XLEN-1:0] memRData;

	// Memory image, model copy and owning test of each word
	logic [`MIPS_XLEN-1:0] mem [MemWords];
	logic [`MIPS_XLEN-1:0] refMem [MemWords];
	int instrTag [MemWords];
	int asmIdx;

	// Expected traces
	logic [`MIPS_XLEN-1:0] expFetch [$];
	logic [`MIPS_XLEN-1:0] expStoreAddr [$];
	logic [`MIPS_XLEN-1:0] expStoreData [$];
	int expStoreTag [$];
	int lastStoreOf [NumTests];
	int totalCycles;

	// Store log from the memory model
	logic [`MIPS_XLEN-1:0] logAddr [$];
	logic [`MIPS_XLEN-1:0] logData [$];
	int logCycle [$];

	string testName [NumTests] = '{"rtypeAlu", "addiNegImm", "loadStoreRoundTrip",
		"beqTakenNotTaken", "jumpTarget", "zeroRegister"};
	int errCount [NumTests];
	int checkCount;
	int testsPassed;
	int testsFailed;
	int totalErrors;
	int cycleCount;
	int fetchIdx;
	int storeIdx;
	int curTag;
	logic [`MIPS_XLEN-1:0] curInstr;
	logic finished;
	logic timedOut;
	integer seed;
	logic [`MIPS_XLEN-1:0] opA;
	logic [`MIPS_XLEN-1:0] opB;
	logic [15:0] negImm;

	mipsCore dut_i (
		.cclk     (cclk),
		.rstb     (rstb),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memWrite (memWrite),
		.memRData (memRData)
	);

	initial begin
		cclk = 1'b0;
		forever #20 cclk = ~cclk;
	end

	// Combinational read, word addressed
	assign memRData = mem[memAddr[10:2]];

	always @(posedge cclk) begin
		if (rstb && memWrite) begin
			mem[memAddr[10:2]] <= memWData;
			logAddr.push_back(memAddr);
			logData.push_back(memWData);
			logCycle.push_back(cycleCount);
		end
	end

	// Instruction encoders
	function automatic logic [31:0] encR(input logic [5:0] fn, input int rs, input int rt,
		input int rd);
		return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] encJ(input int target);
		return {mipsPkg::j, 26'(target)};
	endfunction

	task automatic emit(input int tag, input logic [31:0] word);
		mem[asmIdx] = word;
		instrTag[asmIdx] = tag;
		asmIdx++;
	endtask

	task automatic buildProgram();
		for (int i = 0; i < MemWords; i++) begin
			mem[i] = {~16'(i), 16'(i)};
			instrTag[i] = 0;
		end
		// Operands of opposite sign so slt is a signed test
		opA = $random(seed) | 32'h8000_0000;
		opB = $random(seed) & 32'h7fff_ffff;
		negImm = 16'h8000 | 16'($random(seed));
		mem[128] = opA;
		mem[129] = opB;
		asmIdx = 0;
		emit(0, encI(mipsPkg::lw, 0, 1, 16'h0200));
		emit(0, encI(mipsPkg::lw, 0, 2, 16'h0204));
		emit(0, encR(mipsPkg::functAdd, 1, 2, 3));
		emit(0, encI(mipsPkg::sw, 0, 3, 16'h0300));
		emit(0, encR(mipsPkg::functSub, 1, 2, 4));
		emit(0, encI(mipsPkg::sw, 0, 4, 16'h0304));
		emit(0, encR(mipsPkg::functAnd, 1, 2, 5));
		emit(0, encI(mipsPkg::sw, 0, 5, 16'h0308));
		emit(0, encR(mipsPkg::functOr, 1, 2, 6));
		emit(0, encI(mipsPkg::sw, 0, 6, 16'h030c));
		emit(0, encR(mipsPkg::functSlt, 1, 2, 7));
		emit(0, encI(mipsPkg::sw, 0, 7, 16'h0310));
		emit(0, encR(mipsPkg::functSlt, 2, 1, 8));
		emit(0, encI(mipsPkg::sw, 0, 8, 16'h0314));
		emit(1, encI(mipsPkg::addi, 1, 9, negImm));
		emit(1, encI(mipsPkg::sw, 0, 9, 16'h0318));
		emit(1, encI(mipsPkg::addi, 0, 10, negImm));
		emit(1, encI(mipsPkg::sw, 0, 10, 16'h031c));
		emit(2, encI(mipsPkg::sw, 0, 3, 16'h0320));
		emit(2, encI(mipsPkg::lw, 0, 11, 16'h0320));
		emit(2, encI(mipsPkg::sw, 0, 11, 16'h0324));
		// Taken, then not taken
		emit(3, encI(mipsPkg::beq, 1, 1, 16'd1));
		emit(3, encI(mipsPkg::addi, 0, 12, 16'd1));
		emit(3, encI(mipsPkg::beq, 1, 2, 16'd1));
		emit(3, encI(mipsPkg::addi, 0, 13, 16'd2));
		emit(3, encI(mipsPkg::sw, 0, 12, 16'h0328));
		emit(3, encI(mipsPkg::sw, 0, 13, 16'h032c));
		// Jump over one word
		emit(4, encJ(asmIdx + 2));
		emit(4, encI(mipsPkg::addi, 0, 14, 16'd3));
		emit(4, encI(mipsPkg::addi, 0, 15, 16'd4));
		emit(4, encI(mipsPkg::sw, 0, 14, 16'h0330));
		emit(4, encI(mipsPkg::sw, 0, 15, 16'h0334));
		emit(5, encI(mipsPkg::addi, 0, 0, 16'h1234));
		emit(5, encR(mipsPkg::functAdd, 1, 2, 0));
		emit(5, encI(mipsPkg::sw, 0, 0, 16'h0338));
		// Halt loop, jump to self
		emit(5, encJ(asmIdx));
	endtask

	// Cycles per instruction class
	function automatic int cyclesFor(input logic [5:0] op);
		int n;
		case (op)
			mipsPkg::beq, mipsPkg::j: n = 3;
			mipsPkg::rType, mipsPkg::addi, mipsPkg::sw: n = 4;
			mipsPkg::lw: n = 5;
			default: n = 2;
		endcase
		return n;
	endfunction

	// Expected ALU code per funct
	function automatic mipsPkg::aluCtrl refAluCtrl(input logic [5:0] fn);
		mipsPkg::aluCtrl c;
		case (fn)
			mipsPkg::functSub: c = mipsPkg::aluSub;
			mipsPkg::functAnd: c = mipsPkg::aluAnd;
			mipsPkg::functOr: c = mipsPkg::aluOr;
			mipsPkg::functSlt: c = mipsPkg::aluSlt;
			default: c = mipsPkg::aluAdd;
		endcase
		return c;
	endfunction

	// ISA model, fills the expected traces and returns the cycle total
	function automatic int runReference();
		logic [`MIPS_XLEN-1:0] regs [32];
		logic [`MIPS_XLEN-1:0] pc;
		logic [`MIPS_XLEN-1:0] ins;
		logic [`MIPS_XLEN-1:0] imm;
		logic [`MIPS_XLEN-1:0] a;
		logic [`MIPS_XLEN-1:0] b;
		logic [`MIPS_XLEN-1:0] res;
		logic [`MIPS_XLEN-1:0] addr;
		int cycles;
		int idx;
		for (int i = 0; i < MemWords; i++) begin
			refMem[i] = mem[i];
		end
		for (int r = 0; r < 32; r++) begin
			regs[r] = '0;
		end
		pc = `MIPS_RESET_PC;
		cycles = 0;
		for (int step = 0; step < 200; step++) begin
			idx = pc[10:2];
			ins = refMem[idx];
			if (ins == encJ(idx)) begin
				break;
			end
			expFetch.push_back(pc);
			imm = {{16{ins[15]}}, ins[15:0]};
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			addr = a + imm;
			pc = pc + 4;
			cycles += cyclesFor(ins[31:26]);
			case (ins[31:26])
				mipsPkg::rType: begin
					case (ins[5:0])
						mipsPkg::functSub: res = a - b;
						mipsPkg::functAnd: res = a & b;
						mipsPkg::functOr: res = a | b;
						mipsPkg::functSlt: res = ($signed(a) < $signed(b)) ? 1 : 0;
						default: res = a + b;
					endcase
					if (ins[15:11] != 0) begin
						regs[ins[15:11]] = res;
					end
				end
				mipsPkg::addi: begin
					if (ins[20:16] != 0) begin
						regs[ins[20:16]] = addr;
					end
				end
				mipsPkg::lw: begin
					if (ins[20:16] != 0) begin
						regs[ins[20:16]] = refMem[addr[10:2]];
					end
				end
				mipsPkg::sw: begin
					refMem[addr[10:2]] = b;
					expStoreAddr.push_back(addr);
					expStoreData.push_back(b);
					expStoreTag.push_back(instrTag[idx]);
					lastStoreOf[instrTag[idx]] = expStoreAddr.size() - 1;
				end
				mipsPkg::beq: begin
					if (a == b) begin
						pc = pc + {imm[`MIPS_XLEN-3:0], 2'b00};
					end
				end
				mipsPkg::j: begin
					pc = {pc[`MIPS_XLEN-1:28], ins[25:0], 2'b00};
				end
				default: begin
					res = '0;
				end
			endcase
		end
		return cycles;
	endfunction

	task automatic checkWord(input int tag, input string what,
		input logic [`MIPS_XLEN-1:0] exp, input logic [`MIPS_XLEN-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount[tag]++;
			$display("** Error %s %s: expected %h, actual %h", testName[tag], what, exp, act);
		end
	endtask

	task automatic checkAluCtrl(input int tag, input mipsPkg::aluCtrl exp,
		input mipsPkg::aluCtrl act);
		checkCount++;
		if (act !== exp) begin
			errCount[tag]++;
			$display("** Error %s ALU control: expected %s (%h), actual %s (%h)",
				testName[tag], exp.name(), exp, act.name(), act);
		end
	endtask

	task automatic reportTest(input int tag);
		if (errCount[tag] == 0) begin
			testsPassed++;
			$display("test %-20s ok", testName[tag]);
		end else begin
			testsFailed++;
			$display("test %-20s failed with %0d errors", testName[tag], errCount[tag]);
		end
	endtask

	// Compare against the model on the falling edge
	always @(negedge cclk) begin
		int tag;
		if (rstb && !finished && !timedOut) begin
			cycleCount++;
			// Stores logged at the last rising edge
			if (storeIdx < logAddr.size()) begin
				if (storeIdx >= expStoreAddr.size()) begin
					errCount[NumTests-1]++;
					$display("Store to %h not in the reference trace", logAddr[storeIdx]);
				end else begin
					tag = expStoreTag[storeIdx];
					checkWord(tag, "store address", expStoreAddr[storeIdx], logAddr[storeIdx]);
					checkWord(tag, "store data", expStoreData[storeIdx], logData[storeIdx]);
					if (storeIdx == lastStoreOf[tag]) begin
						// Final store closes the run
						if (tag == NumTests - 1) begin
							checkWord(tag, "cycles to final store", totalCycles,
								logCycle[storeIdx]);
							checkWord(tag, "fetch count", expFetch.size(), fetchIdx);
							finished = 1'b1;
						end
						reportTest(tag);
					end
				end
				storeIdx++;
			end
			if (!finished && dut_i.irWrite) begin
				curInstr = memRData;
				curTag = instrTag[memAddr[10:2]];
				if (fetchIdx < expFetch.size()) begin
					checkWord(curTag, $sformatf("fetch %0d address", fetchIdx),
						expFetch[fetchIdx], memAddr);
				end else begin
					errCount[curTag]++;
					$display("Fetch from %h past the end of the reference trace", memAddr);
				end
				fetchIdx++;
			end
			if (!finished && dut_i.controlUnit_i.state == mipsPkg::execute) begin
				checkAluCtrl(curTag, refAluCtrl(curInstr[5:0]), dut_i.aluControl);
			end
			if (!finished && cycleCount > totalCycles + 20) begin
				timedOut = 1'b1;
			end
		end
	end

	initial begin
		rstb = 1'b0;
		finished = 1'b0;
		timedOut = 1'b0;
		cycleCount = 0;
		fetchIdx = 0;
		storeIdx = 0;
		curTag = 0;
		curInstr = '0;
		checkCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		totalErrors = 0;
		seed = 32'h0c13_6b2c;
		for (int t = 0; t < NumTests; t++) begin
			errCount[t] = 0;
			lastStoreOf[t] = -1;
		end
		buildProgram();
		totalCycles = runReference();
		repeat (4) @(posedge cclk);
		rstb <= 1'b1;
		wait (finished || timedOut);
		@(posedge cclk);
		for (int t = 0; t < NumTests; t++) begin
			totalErrors += errCount[t];
		end
		totalErrors += dut_i.controlUnit_i.mipsCore_asserts_i.assertFails;
		if (timedOut) begin
			testsFailed = NumTests - testsPassed;
		end
		$display("tests %0d, passed %0d, failed %0d, checks %0d, assertion failures %0d",
			NumTests, testsPassed, testsFailed, checkCount,
			dut_i.controlUnit_i.mipsCore_asserts_i.assertFails);
		if (!timedOut && totalErrors == 0 && testsFailed == 0) begin
			$display("** PASS **");
		end else begin
			if (timedOut) begin
				$display("Timeout after %0d cycles, the final store never arrived", cycleCount);
			end
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
